// File: verilog/imu_spi_pkg.sv
package imu_spi_pkg;

    // ==============================
    // Packet constants
    // ==============================

    // Bytes in one packet from the microcontroller
    localparam int unsigned PACKET_BYTES = 16;

    // Width of the byte index in the SCK domain
    localparam int unsigned BYTE_IDX_W = $clog2(PACKET_BYTES);

    // Every good packet starts with this byte
    localparam logic [7:0] HEADER_BYTE = 8'hAA;

    // Q14 encoding of 1.0, used as the fixed quaternion w
    localparam logic signed [15:0] QUAT_W_ONE = 16'sd16384;

    // clk cycles the synchronized select must stay high before the buffer is read
    localparam int unsigned STABLE_CYCLES = 3;
    localparam int unsigned STABLE_CNT_W = $clog2(STABLE_CYCLES + 1);

    // ==============================
    // Packet and output types
    // ==============================

    // Index 0 is the first byte on the wire and sits in the top bits,
    // so a plain cast to imu_packet_t lines the fields up
    typedef logic [0:PACKET_BYTES-1][7:0] packet_bytes_t;

    // Fields in wire order, all 16-bit values MSB first
    typedef struct packed {
        logic [7:0]         header;
        logic signed [15:0] roll;
        logic signed [15:0] pitch;
        logic signed [15:0] yaw;
        logic signed [15:0] gyro_x;
        logic signed [15:0] gyro_y;
        logic signed [15:0] gyro_z;
        logic [7:0]         flags;
        logic [15:0]        reserved;
    } imu_packet_t;

    // Euler angles carried in the quaternion x/y/z slots
    typedef struct packed {
        logic               valid;
        logic signed [15:0] w;
        logic signed [15:0] x;
        logic signed [15:0] y;
        logic signed [15:0] z;
    } attitude_t;

    typedef struct packed {
        logic               valid;
        logic signed [15:0] x;
        logic signed [15:0] y;
        logic signed [15:0] z;
    } gyro_t;

    typedef struct packed {
        logic initialized;
        logic error;
    } status_t;

endpackage

// File: verilog/spi_rx_shifter.sv
module spi_rx_shifter import imu_spi_pkg::*; (
    input  logic          cs_n,
    input  logic          ss_n,
    input  logic          sck,
    input  logic          sdi,
    output packet_bytes_t packet_buffer
);

    // ==============================
    // SCK domain receive state
    // ==============================

    // Counters restart whenever the master deselects us or the system resets
    logic rx_clear;
    assign rx_clear = cs_n | ss_n;

    // Seven bits received so far; the eighth is taken straight from sdi
    logic [6:0] shift_q;
    logic [2:0] bit_cnt;
    logic [BYTE_IDX_W-1:0] byte_idx;

    // Byte completed by the current SCK edge
    logic [7:0] rx_byte;
    assign rx_byte = {shift_q, sdi};

    logic last_bit;
    assign last_bit = (bit_cnt == 3'd7);

    // Mode 0 samples sdi on the rising SCK edge, MSB first
    always_ff @(posedge sck or posedge rx_clear) begin
        if (rx_clear) begin
            shift_q  <= '0;
            bit_cnt  <= '0;
            byte_idx <= '0;
        end else begin
            shift_q <= rx_byte[6:0];
            bit_cnt <= bit_cnt + 3'd1;
            if (last_bit) begin
                // Saturate on the last slot so that extra bytes overwrite it
                if (byte_idx != BYTE_IDX_W'(PACKET_BYTES - 1)) begin
                    byte_idx <= byte_idx + 1'b1;
                end
            end
        end
    end

    // ==============================
    // Packet buffer
    // ==============================

    // The buffer is not cleared on deselect. It keeps the finished packet
    // so that the clk domain can copy it while SCK is idle
    always_ff @(posedge sck) begin
        if (!rx_clear && last_bit) begin
            packet_buffer[byte_idx] <= rx_byte;
        end
    end

    // After a finished byte the index has left slot 0 for good. Running past
    // the last slot would wrap it back there and corrupt the first byte
    a_byte_idx_range: assert property (
        @(negedge sck) disable iff (rx_clear)
        (bit_cnt == 3'd0) |-> (byte_idx != '0)
    );

endmodule

// File: verilog/packet_capture.sv
module packet_capture import imu_spi_pkg::*; (
    input  logic          clk,
    input  logic          cs_n,
    input  logic          ss_n,
    input  packet_bytes_t packet_buffer,
    output imu_packet_t   snapshot,
    output logic          snap_valid
);

    // ==============================
    // Chip select synchronizer
    // ==============================

    // Two flops bring ss_n into clk, a third keeps the previous value
    // for edge detection. All reset to the deselected level
    logic ss_meta;
    logic ss_sync;
    logic ss_prev;

    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            ss_meta <= 1'b1;
            ss_sync <= 1'b1;
            ss_prev <= 1'b1;
        end else begin
            ss_meta <= ss_n;
            ss_sync <= ss_meta;
            ss_prev <= ss_sync;
        end
    end

    logic ss_fall;
    assign ss_fall = ss_prev & ~ss_sync;

    // ==============================
    // Stable-high wait and snapshot
    // ==============================

    // Counts clk cycles with the select high, saturating at STABLE_CYCLES
    logic [STABLE_CNT_W-1:0] stable_cnt;
    logic stable;
    assign stable = (stable_cnt == STABLE_CNT_W'(STABLE_CYCLES));

    // Set by a falling select edge, cleared once the packet is taken.
    // Out of reset it is low, so no snapshot happens before the first transfer
    logic armed;
    logic take;
    assign take = armed & ss_sync & stable;

    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            stable_cnt <= '0;
            armed      <= 1'b0;
            snap_valid <= 1'b0;
        end else begin
            if (!ss_sync) begin
                stable_cnt <= '0;
            end else if (!stable) begin
                stable_cnt <= stable_cnt + 1'b1;
            end
            if (ss_fall) begin
                armed <= 1'b1;
            end else if (take) begin
                armed <= 1'b0;
            end
            snap_valid <= take;
        end
    end

    // SCK is idle by now, so all sixteen bytes are copied in one cycle
    always_ff @(posedge clk) begin
        if (take) begin
            snapshot <= imu_packet_t'(packet_buffer);
        end
    end

    // One transfer gives one pulse, the parser relies on it
    a_single_pulse: assert property (
        @(posedge clk) disable iff (cs_n)
        snap_valid |=> !snap_valid
    );

endmodule

// File: verilog/imu_packet_parser.sv
module imu_packet_parser import imu_spi_pkg::*; (
    input  logic        clk,
    input  logic        cs_n,
    input  imu_packet_t snapshot,
    input  logic        snap_valid,
    output status_t     status,
    output attitude_t   attitude,
    output gyro_t       gyro
);

    // ==============================
    // Field register stage
    // ==============================

    // Local copy of the packet, loaded only when a new snapshot arrives
    imu_packet_t pkt_q;
    logic        fields_valid;

    always_ff @(posedge clk) begin
        if (snap_valid) begin
            pkt_q <= snapshot;
        end
    end

    // Marks the cycle in which pkt_q holds a fresh packet
    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            fields_valid <= 1'b0;
        end else begin
            fields_valid <= snap_valid;
        end
    end

    logic header_ok;
    assign header_ok = (pkt_q.header == HEADER_BYTE);

    // ==============================
    // Header check and output stage
    // ==============================

    // Outputs hold between packets. A bad header only touches status,
    // attitude and gyro keep the last good packet
    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            status   <= '0;
            attitude <= '0;
            gyro     <= '0;
        end else if (fields_valid) begin
            if (header_ok) begin
                status.initialized <= 1'b1;
                status.error       <= 1'b0;

                // Roll, pitch and yaw go into the x/y/z slots with w fixed at 1.0
                attitude.valid <= pkt_q.flags[0];
                attitude.w     <= QUAT_W_ONE;
                attitude.x     <= pkt_q.roll;
                attitude.y     <= pkt_q.pitch;
                attitude.z     <= pkt_q.yaw;

                // gyro passes straight through
                gyro.valid <= pkt_q.flags[1];
                gyro.x     <= pkt_q.gyro_x;
                gyro.y     <= pkt_q.gyro_y;
                gyro.z     <= pkt_q.gyro_z;
            end else begin
                status.initialized <= 1'b0;
                status.error       <= 1'b1;
            end
        end
    end

    // The downstream consumer treats these two as exclusive states
    a_status_exclusive: assert property (
        @(posedge clk) disable iff (cs_n)
        !(status.initialized && status.error)
    );

endmodule

// File: verilog/imu_spi_rx_top.sv
module imu_spi_rx_top import imu_spi_pkg::*; (
    input  logic      clk,
    input  logic      cs_n,
    input  logic      ss_n,
    input  logic      sck,
    input  logic      sdi,
    output status_t   status,
    output attitude_t attitude,
    output gyro_t     gyro
);

    // ==============================
    // Stage interconnect
    // ==============================

    // Written on SCK, read in clk only while the select is high and SCK idle
    packet_bytes_t packet_buffer;

    // Held copy of the last packet and its one-cycle strobe
    imu_packet_t snapshot;
    logic        snap_valid;

    // SCK domain receiver
    spi_rx_shifter u_shifter (
        .cs_n          (cs_n),
        .ss_n          (ss_n),
        .sck           (sck),
        .sdi           (sdi),
        .packet_buffer (packet_buffer)
    );

    // Crossing into clk once the transfer is over
    packet_capture u_capture (
        .clk           (clk),
        .cs_n          (cs_n),
        .ss_n          (ss_n),
        .packet_buffer (packet_buffer),
        .snapshot      (snapshot),
        .snap_valid    (snap_valid)
    );

    // Field split, header check and registered outputs
    imu_packet_parser u_parser (
        .clk        (clk),
        .cs_n       (cs_n),
        .snapshot   (snapshot),
        .snap_valid (snap_valid),
        .status     (status),
        .attitude   (attitude),
        .gyro       (gyro)
    );

endmodule

// File: verif/tb_imu_spi_rx.sv
module tb_imu_spi_rx import imu_spi_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    // ==============================
    // DUT and clock
    // ==============================

    logic      clk;
    logic      cs_n;
    logic      ss_n;
    logic      sck;
    logic      sdi;
    status_t   status;
    attitude_t attitude;
    gyro_t     gyro;

    imu_spi_rx_top dut_i (
        .clk      (clk),
        .cs_n     (cs_n),
        .ss_n     (ss_n),
        .sck      (sck),
        .sdi      (sdi),
        .status   (status),
        .attitude (attitude),
        .gyro     (gyro)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Stimulus and expected results hold one entry per golden line
    packet_bytes_t pkt_q[$];
    status_t       exp_status_q[$];
    attitude_t     exp_att_q[$];
    gyro_t         exp_gyro_q[$];

    int    mismatch_cnt = 0;
    int    other_cnt = 0;
    logic  wd_armed = 1'b0;
    longint wd_ns = 0;

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clk);
    endtask

    // ==============================
    // Golden file reader
    // ==============================

    // Each line has 16 packet bytes, then init, error, att valid/x/y/z and gyro valid/x/y/z
    task automatic load_golden();
        int          fd;
        int          cnt;
        int          line_no;
        string       line;
        int unsigned v [26];
        logic        bad;
        logic        good_seen;
        packet_bytes_t pkt;
        status_t     st;
        attitude_t   att;
        gyro_t       gy;
        line_no = 0;
        good_seen = 1'b0;
        fd = $fopen("verif/imu_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file verif/imu_golden.txt");
            other_cnt++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            line_no++;
            // Comment and blank lines carry no packet
            if (line.len() < 2 || line.getc(0) == "#") continue;
            cnt = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11],
                v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19], v[20], v[21],
                v[22], v[23], v[24], v[25]);
            bad = (cnt != 26);
            for (int i = 0; i < 26; i++) begin
                if (i < 16 && v[i] > 255) bad = 1'b1;
                if ((i == 16 || i == 17 || i == 18 || i == 22) && v[i] > 1) bad = 1'b1;
                if (v[i] > 65535) bad = 1'b1;
            end
            if (bad) begin
                $display("Golden file line %0d is malformed and was skipped", line_no);
                other_cnt++;
                continue;
            end
            for (int i = 0; i < PACKET_BYTES; i++) pkt[i] = v[i][7:0];
            st.initialized = v[16][0];
            st.error       = v[17][0];
            // w only becomes 1.0 once a packet with a good header has been taken
            good_seen = good_seen | st.initialized;
            att.valid = v[18][0];
            att.w     = good_seen ? 16'sd16384 : 16'sd0;
            att.x     = v[19][15:0];
            att.y     = v[20][15:0];
            att.z     = v[21][15:0];
            gy.valid  = v[22][0];
            gy.x      = v[23][15:0];
            gy.y      = v[24][15:0];
            gy.z      = v[25][15:0];
            pkt_q.push_back(pkt);
            exp_status_q.push_back(st);
            exp_att_q.push_back(att);
            exp_gyro_q.push_back(gy);
        end
        $fclose(fd);
        if (pkt_q.size() == 0) begin
            $display("The golden file holds no packets");
            other_cnt++;
        end
    endtask

    // ==============================
    // Compare tasks
    // ==============================

    task automatic report_mismatch(input string tag, input string field,
                                   input int got, input int exp);
        $display("MISMATCH at %0t ns: %s %s got %0d expected %0d",
                 $time, tag, field, got, exp);
        mismatch_cnt++;
    endtask

    task automatic check_status(input status_t got, input status_t exp, input string tag);
        if (got.initialized !== exp.initialized)
            report_mismatch(tag, "status.initialized", int'(got.initialized),
                            int'(exp.initialized));
        if (got.error !== exp.error)
            report_mismatch(tag, "status.error", int'(got.error), int'(exp.error));
    endtask

    task automatic check_attitude(input attitude_t got, input attitude_t exp, input string tag);
        if (got.valid !== exp.valid)
            report_mismatch(tag, "attitude.valid", int'(got.valid), int'(exp.valid));
        if (got.w !== exp.w) report_mismatch(tag, "attitude.w", int'(got.w), int'(exp.w));
        if (got.x !== exp.x) report_mismatch(tag, "attitude.x", int'(got.x), int'(exp.x));
        if (got.y !== exp.y) report_mismatch(tag, "attitude.y", int'(got.y), int'(exp.y));
        if (got.z !== exp.z) report_mismatch(tag, "attitude.z", int'(got.z), int'(exp.z));
    endtask

    task automatic check_gyro(input gyro_t got, input gyro_t exp, input string tag);
        if (got.valid !== exp.valid)
            report_mismatch(tag, "gyro.valid", int'(got.valid), int'(exp.valid));
        if (got.x !== exp.x) report_mismatch(tag, "gyro.x", int'(got.x), int'(exp.x));
        if (got.y !== exp.y) report_mismatch(tag, "gyro.y", int'(got.y), int'(exp.y));
        if (got.z !== exp.z) report_mismatch(tag, "gyro.z", int'(got.z), int'(exp.z));
    endtask

    // ==============================
    // SPI master, Mode 0
    // ==============================

    // Data changes with SCK low and is sampled by the DUT on the rising edge
    task automatic send_packet(input packet_bytes_t pkt, input int half);
        ss_n <= 1'b0;
        for (int i = 0; i < PACKET_BYTES; i++) begin
            for (int k = 7; k >= 0; k--) begin
                sdi <= pkt[i][k];
                wait_clocks(half);
                sck <= 1'b1;
                wait_clocks(half);
                sck <= 1'b0;
            end
        end
        wait_clocks(half);
        ss_n <= 1'b1;
        sdi  <= 1'b0;
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        int    gap;
        int    half;
        string tag;
        void'($urandom(97));
        cs_n = 1'b1;
        ss_n = 1'b1;
        sck  = 1'b0;
        sdi  = 1'b0;
        load_golden();
        // Each packet takes at most the slowest SCK, the longest gap and the settle wait
        wd_ns = longint'(pkt_q.size()) * (2 * 128 * 6 + 60 + 16) * 10 + 20000;
        wd_armed = 1'b1;
        wait_clocks(3);
        cs_n <= 1'b0;
        wait_clocks(2);
        // Nothing has been received, so every output is still at its reset value
        check_status(status, status_t'(0), "after reset");
        check_attitude(attitude, attitude_t'(0), "after reset");
        check_gyro(gyro, gyro_t'(0), "after reset");
        for (int p = 0; p < pkt_q.size(); p++) begin
            gap  = 20 + int'($urandom % 41);
            half = 3 + int'($urandom % 4);
            wait_clocks(gap);
            send_packet(pkt_q[p], half);
            // The outputs settle within 10 cycles of ss_n rising
            wait_clocks(16);
            tag = $sformatf("packet %0d", p);
            check_status(status, exp_status_q[p], tag);
            check_attitude(attitude, exp_att_q[p], tag);
            check_gyro(gyro, exp_gyro_q[p], tag);
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the number of packets once the golden file is read
    initial begin
        wait (wd_armed);
        #(wd_ns);
        $display("Timeout: the run did not finish within %0d ns", wd_ns);
        other_cnt++;
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: verif/imu_golden.txt
# hdr roll(2) pitch(2) yaw(2) gx(2) gy(2) gz(2) flags res(2), all hex bytes in wire order
# then: init err att_valid att_x att_y att_z gyro_valid gyro_x gyro_y gyro_z
AA 12 34 FE DC 7F FF 00 64 FF 9C 80 00 03 00 00 1 0 1 1234 FEDC 7FFF 1 0064 FF9C 8000
AA 00 01 00 02 00 03 00 04 00 05 00 06 00 55 55 1 0 0 0001 0002 0003 0 0004 0005 0006
AA FF FF 80 00 40 00 01 00 02 00 03 00 01 00 00 1 0 1 FFFF 8000 4000 0 0100 0200 0300
AA 0A 0B 0C 0D 0E 0F 10 11 12 13 14 15 02 12 34 1 0 0 0A0B 0C0D 0E0F 1 1011 1213 1415
55 11 11 22 22 33 33 44 44 55 55 66 66 03 00 00 0 1 0 0A0B 0C0D 0E0F 1 1011 1213 1415
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 1 0 0A0B 0C0D 0E0F 1 1011 1213 1415
AB 7F 7F 01 01 02 02 03 03 04 04 05 05 03 00 00 0 1 0 0A0B 0C0D 0E0F 1 1011 1213 1415
AA C0 00 3F FF 00 00 FF FF 00 01 7F 00 03 00 00 1 0 1 C000 3FFF 0000 1 FFFF 0001 7F00
AA 01 23 45 67 89 AB CD EF 01 23 45 67 01 00 00 1 0 1 0123 4567 89AB 0 CDEF 0123 4567
AA 76 54 32 10 FE DC BA 98 76 54 32 10 02 FF FF 1 0 0 7654 3210 FEDC 1 BA98 7654 3210
AA 80 01 7F FE 00 10 FF F0 12 34 ED CC FC 00 00 1 0 0 8001 7FFE 0010 0 FFF0 1234 EDCC

// File: verilog.f
verilog/imu_spi_pkg.sv
verilog/spi_rx_shifter.sv
verilog/packet_capture.sv
verilog/imu_packet_parser.sv
verilog/imu_spi_rx_top.sv
verif/tb_imu_spi_rx.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_imu_spi_rx -f verilog.f -Mdir obj_dir -o sim_imu
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_imu)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
